// ==== Makefile ====
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/cpu_sequencer.sv
verilog/program_counter.sv
verilog/program_ram.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu_top.sv

// ==== testbench/cpu_checker.sv ====
////////////////////////////////////////
// watches the CPU ports and predicts each output
// assumes in_data is constant while a program runs
// the model is cleared by reset, like the program RAM
////////////////////////////////////////

`timescale 1ns/1ps

module cpu_checker import cpu_isa_pkg::*; #(
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  run,
  input  logic                  load_en,
  input  logic [addr_width-1:0] load_addr,
  input  logic [7:0]            load_data,
  input  logic [7:0]            in_data,
  input  logic [7:0]            out_data,
  input  logic                  out_valid,
  output int                    out_count,
  output int                    mismatch_count,
  output int                    other_count
);

  localparam int depth = 2 ** addr_width;

  logic [7:0]            image [depth];
  logic [addr_width-1:0] m_pc;
  logic [7:0]            m_a;
  logic [7:0]            m_b;
  logic [7:0]            m_c;
  logic [7:0]            expected;
  bit                    found;
  logic                  run_d1;
  logic                  run_d2;

  int n_outputs = 0;
  int n_mismatch = 0;
  int n_other = 0;

  assign out_count      = n_outputs;
  assign mismatch_count = n_mismatch;
  assign other_count    = n_other;

  // steps the model up to the next OUT with a valid register select
  function automatic logic [7:0] predict_output(input logic [7:0] din, output bit hit);
    logic [7:0] ins;
    logic [3:0] op;
    logic [3:0] opd;
    logic [7:0] result;
    hit = 1'b0;
    result = '0;
    for (int step = 0; step < 64 && !hit; step++) begin
      ins = image[m_pc];
      op = ins[7:4];
      opd = ins[3:0];
      m_pc = m_pc + 1'b1;
      case (op)
        op_lda_lo: m_a[3:0] = opd;
        op_lda_hi: m_a[7:4] = opd;
        op_ldb_lo: m_b[3:0] = opd;
        op_ldb_hi: m_b[7:4] = opd;
        op_ldc_lo: m_c[3:0] = opd;
        op_ldc_hi: m_c[7:4] = opd;
        op_add:    m_c = m_a + m_b;
        op_sub:    m_c = m_a - m_b;
        op_mul:    m_c = m_a * m_b;
        op_in: begin
          if (opd == reg_a) m_a = din;
          else if (opd == reg_b) m_b = din;
          else if (opd == reg_c) m_c = din;
        end
        op_out: begin
          if (opd == reg_a || opd == reg_b || opd == reg_c) begin
            hit = 1'b1;
            result = (opd == reg_a) ? m_a : ((opd == reg_b) ? m_b : m_c);
          end
        end
        default: ;
      endcase
    end
    return result;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        image[i] = '0;
      end
      m_pc = '0;
      m_a = '0;
      m_b = '0;
      m_c = '0;
      run_d1 = 1'b0;
      run_d2 = 1'b0;
    end else begin
      if (load_en) begin
        image[load_addr] = load_data;
      end
      // an output needs run high at the edge that ended its fetch
      if (out_valid && !run_d2) begin
        n_other++;
        $display("ERROR: out_valid pulsed although run was low when its fetch ended");
      end
      if (out_valid) begin
        n_outputs++;
        expected = predict_output(in_data, found);
        if (!found) begin
          n_other++;
          $display("ERROR: out_valid pulsed but no OUT is reachable within 64 steps");
        end else if (out_data !== expected) begin
          n_mismatch++;
          $display("MISMATCH out_data: got %h expected %h", out_data, expected);
        end
      end
      run_d2 = run_d1;
      run_d1 = run;
    end
  end

endmodule

// ==== testbench/tb_cpu_top.sv ====
////////////////////////////////////////
// testbench for the 8-bit CPU
// every program runs from a fresh reset
// inputs change on the falling clock edge only
////////////////////////////////////////

`timescale 1ns/1ps

module tb_cpu_top import cpu_isa_pkg::*; ();

  localparam int addr_width = 4;
  localparam int depth = 2 ** addr_width;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  run;
  logic                  load_en;
  logic [addr_width-1:0] load_addr;
  logic [7:0]            load_data;
  logic [7:0]            in_data;
  logic [7:0]            out_data;
  logic                  out_valid;

  int          out_count;
  int          mismatch_count;
  int          other_count;
  int          tb_errors = 0;
  logic [31:0] lfsr = 32'h6262;
  logic [31:0] rnd;
  logic [7:0]  va;
  logic [7:0]  vb;
  logic [7:0]  vc;
  logic [7:0]  prog [depth];

  always #4 clk = ~clk;

  cpu_top #(.addr_width(addr_width)) dut (
    .clk(clk), .reset(reset), .run(run), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .in_data(in_data), .out_data(out_data), .out_valid(out_valid)
  );

  cpu_checker #(.addr_width(addr_width)) u_checker (
    .clk(clk), .reset(reset), .run(run), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .in_data(in_data), .out_data(out_data), .out_valid(out_valid),
    .out_count(out_count), .mismatch_count(mismatch_count), .other_count(other_count)
  );

  function automatic logic [7:0] encode(input logic [3:0] op, input logic [3:0] operand);
    return {op, operand};
  endfunction

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return val;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    run = 1'b0;
    load_en = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic fill_nops();
    for (int i = 0; i < depth; i++) begin
      prog[i] = encode(op_nop, 4'd0);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < depth; i++) begin
      @(negedge clk);
      load_en = 1'b1;
      load_addr = addr_width'(i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // out_valid low and out_data zero for the whole window
  task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        tb_errors++;
        $display("MISMATCH out_valid: got %h expected %h", out_valid, 1'b0);
      end
      if (out_data !== 8'h00) begin
        tb_errors++;
        $display("MISMATCH out_data: got %h expected %h", out_data, 8'h00);
      end
    end
  endtask

  // reset, load, then run until n_out more outputs or timeout
  task automatic run_case(input int n_out, input bit drop_run);
    int target;
    int cycles;
    apply_reset();
    load_program();
    target = out_count + n_out;
    cycles = 0;
    run = 1'b1;
    while (out_count < target && cycles < 1000) begin
      @(negedge clk);
      cycles++;
      if (drop_run) begin
        rnd = take_bits(2);
        run = (rnd[1:0] != 2'b00);
      end
    end
    if (out_count < target) begin
      tb_errors++;
      $display("ERROR: timeout, expected %0d outputs but saw %0d", target, out_count);
    end
    run = 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    run = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    in_data = '0;
    apply_reset();

    // loaded but not running, then an all-zero program running
    fill_nops();
    prog[0] = encode(op_lda_lo, 4'd9);
    prog[1] = encode(op_out, reg_a);
    load_program();
    check_quiet(20);
    apply_reset();
    run = 1'b1;
    check_quiet(100);
    run = 1'b0;

    // nibble loads that each keep the other half
    for (int t = 0; t < 4; t++) begin
      rnd = take_bits(24);
      va = rnd[7:0];
      vb = rnd[15:8];
      vc = rnd[23:16];
      fill_nops();
      prog[0] = encode(op_lda_hi, va[7:4]);
      prog[1] = encode(op_lda_lo, va[3:0]);
      prog[2] = encode(op_ldb_lo, vb[3:0]);
      prog[3] = encode(op_ldb_hi, vb[7:4]);
      prog[4] = encode(op_ldc_lo, vc[3:0]);
      prog[5] = encode(op_ldc_hi, vc[7:4]);
      prog[6] = encode(op_out, reg_a);
      prog[7] = encode(op_out, reg_b);
      prog[8] = encode(op_out, reg_c);
      prog[9] = encode(op_lda_hi, vc[3:0]);
      prog[10] = encode(op_out, reg_a);
      prog[11] = encode(op_lda_lo, vb[7:4]);
      prog[12] = encode(op_out, reg_a);
      run_case(5, 1'b0);
    end

    // add, sub and mul on random operands
    for (int t = 0; t < 12; t++) begin
      rnd = take_bits(16);
      va = rnd[7:0];
      vb = rnd[15:8];
      fill_nops();
      prog[0] = encode(op_lda_lo, va[3:0]);
      prog[1] = encode(op_lda_hi, va[7:4]);
      prog[2] = encode(op_ldb_lo, vb[3:0]);
      prog[3] = encode(op_ldb_hi, vb[7:4]);
      prog[4] = encode(op_add, 4'd0);
      prog[5] = encode(op_out, reg_c);
      prog[6] = encode(op_sub, 4'd0);
      prog[7] = encode(op_out, reg_c);
      prog[8] = encode(op_mul, 4'd0);
      prog[9] = encode(op_out, reg_c);
      run_case(3, 1'b0);
    end

    // IN into each register in turn
    for (int t = 0; t < 3; t++) begin
      rnd = take_bits(8);
      in_data = rnd[7:0];
      fill_nops();
      prog[0] = encode(op_in, reg_a);
      prog[1] = encode(op_out, reg_a);
      prog[2] = encode(op_out, reg_b);
      prog[3] = encode(op_out, reg_c);
      prog[4] = encode(op_in, reg_b);
      prog[5] = encode(op_out, reg_b);
      prog[6] = encode(op_out, reg_c);
      prog[7] = encode(op_in, reg_c);
      prog[8] = encode(op_out, reg_c);
      run_case(6, 1'b0);
    end

    // counter wrap with run steady first and then dropped at random
    for (int d = 0; d < 2; d++) begin
      rnd = take_bits(16);
      in_data = rnd[7:0];
      fill_nops();
      prog[0] = encode(op_lda_lo, rnd[11:8]);
      prog[1] = encode(op_ldb_hi, rnd[15:12]);
      prog[2] = encode(op_out, reg_a);
      prog[3] = encode(op_add, 4'd0);
      prog[4] = encode(op_out, reg_c);
      prog[9] = encode(op_in, reg_b);
      prog[13] = encode(op_out, reg_b);
      run_case(12, d == 1);
    end

    // undefined opcodes and out of range selects do nothing
    rnd = take_bits(20);
    in_data = rnd[7:0] | 8'h01;
    fill_nops();
    prog[0] = encode(op_lda_lo, 4'd5);
    prog[1] = encode(4'd12, rnd[11:8]);
    prog[2] = encode(4'd13, rnd[15:12]);
    prog[3] = encode(op_out, reg_a);
    prog[4] = encode(op_in, 4'd7);
    prog[5] = encode(4'd14, rnd[19:16]);
    prog[6] = encode(op_out, reg_a);
    prog[7] = encode(op_out, 4'd9);
    prog[8] = encode(4'd15, 4'd3);
    prog[9] = encode(op_ldb_lo, 4'd3);
    prog[10] = encode(op_out, 4'd15);
    prog[11] = encode(op_in, 4'd3);
    prog[12] = encode(op_out, reg_b);
    prog[13] = encode(op_out, reg_c);
    run_case(8, 1'b0);

    repeat (4) @(negedge clk);
    $display("errors: mismatch=%0d other=%0d testbench=%0d outputs=%0d",
             mismatch_count, other_count, tb_errors, out_count);
    if (mismatch_count + other_count + tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/cpu_ctrl_pkg.sv ====
////////////////////////////////////////
// control states of the CPU sequencer
////////////////////////////////////////

package cpu_ctrl_pkg;

  // idle while run is low, then fetch and execute alternate
  typedef enum logic [1:0] {
    seq_idle  = 2'd0,
    seq_fetch = 2'd1,
    seq_exec  = 2'd2
  } seq_state_e;

endpackage

// ==== verilog/cpu_datapath.sv ====
////////////////////////////////////////
// decoder, registers A/B/C and output port
// instr must be valid while exec_en is high
// arithmetic results are modulo 256
////////////////////////////////////////

`timescale 1ns/1ps

module cpu_datapath import cpu_isa_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec_en,
  input  logic [data_width-1:0] instr,
  input  logic [data_width-1:0] in_data,
  output logic [data_width-1:0] out_data,
  output logic                  out_valid
);

  opcode_e                  opcode;
  logic [operand_width-1:0] operand;
  reg_sel_e                 sel;

  logic [data_width-1:0] a_q;
  logic [data_width-1:0] b_q;
  logic [data_width-1:0] c_q;

  logic [data_width-1:0] sum;
  logic [data_width-1:0] diff;
  logic [data_width-1:0] prod;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign opcode  = opcode_e'(instr[data_width-1 -: opcode_width]);
  assign operand = instr[operand_width-1:0];
  assign sel     = reg_sel_e'(operand);

  ////////////////////////////////////////
  // arithmetic unit
  ////////////////////////////////////////

  // upper bits drop off, which gives the modulo
  assign sum  = a_q + b_q;
  assign diff = a_q - b_q;
  assign prod = a_q * b_q;

  ////////////////////////////////////////
  // registers and output
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      a_q       <= '0;
      b_q       <= '0;
      c_q       <= '0;
      out_data  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (exec_en) begin
        case (opcode)
          // nibble loads keep the other half
          op_lda_lo: a_q <= {a_q[data_width-1:operand_width], operand};
          op_lda_hi: a_q <= {operand, a_q[operand_width-1:0]};
          op_ldb_lo: b_q <= {b_q[data_width-1:operand_width], operand};
          op_ldb_hi: b_q <= {operand, b_q[operand_width-1:0]};
          op_ldc_lo: c_q <= {c_q[data_width-1:operand_width], operand};
          op_ldc_hi: c_q <= {operand, c_q[operand_width-1:0]};
          op_add:    c_q <= sum;
          op_sub:    c_q <= diff;
          op_mul:    c_q <= prod;
          op_in: begin
            case (sel)
              reg_a:   a_q <= in_data;
              reg_b:   b_q <= in_data;
              reg_c:   c_q <= in_data;
              default: ;
            endcase
          end
          op_out: begin
            // out of range operand gives no pulse
            case (sel)
              reg_a: begin
                out_data  <= a_q;
                out_valid <= 1'b1;
              end
              reg_b: begin
                out_data  <= b_q;
                out_valid <= 1'b1;
              end
              reg_c: begin
                out_data  <= c_q;
                out_valid <= 1'b1;
              end
              default: ;
            endcase
          end
          // nop and undefined opcodes 12..15
          default: ;
        endcase
      end
    end
  end

  // relies on the sequencer spacing execute cycles apart
  out_valid_single: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |=> !out_valid
  );

endmodule

// ==== verilog/cpu_isa_pkg.sv ====
////////////////////////////////////////
// instruction set of the 8-bit CPU
// instr is {opcode, operand}, 4 bits each
// opcodes 12..15 are not defined and act as no-ops
////////////////////////////////////////

package cpu_isa_pkg;

  // register and data byte width
  localparam int data_width = 8;

  // instruction fields, upper and lower nibble
  localparam int opcode_width = 4;
  localparam int operand_width = 4;

  typedef enum logic [opcode_width-1:0] {
    op_nop    = 4'd0,
    op_lda_lo = 4'd1,
    op_lda_hi = 4'd2,
    op_ldb_lo = 4'd3,
    op_ldb_hi = 4'd4,
    op_ldc_lo = 4'd5,
    op_ldc_hi = 4'd6,
    op_add    = 4'd7,
    op_sub    = 4'd8,
    op_mul    = 4'd9,
    op_out    = 4'd10,
    op_in     = 4'd11
  } opcode_e;

  // operand of IN and OUT, values above 2 select nothing
  typedef enum logic [operand_width-1:0] {
    reg_a = 4'd0,
    reg_b = 4'd1,
    reg_c = 4'd2
  } reg_sel_e;

endpackage

// ==== verilog/cpu_sequencer.sv ====
////////////////////////////////////////
// two cycles per instruction while run is high
// run low during fetch drops that fetch, so the
// same address is read again on restart
////////////////////////////////////////

`timescale 1ns/1ps

module cpu_sequencer import cpu_ctrl_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic run,
  output logic fetch_en,
  output logic exec_en
);

  seq_state_e state;
  seq_state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= seq_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      seq_idle: begin
        if (run) begin
          state_next = seq_fetch;
        end
      end
      // a fetch only counts if run is still high
      seq_fetch: state_next = run ? seq_exec : seq_idle;
      seq_exec:  state_next = run ? seq_fetch : seq_idle;
      default:   state_next = seq_idle;
    endcase
  end

  assign fetch_en = (state == seq_fetch);
  assign exec_en  = (state == seq_exec);

  // execute always follows a fetch, never itself
  exec_not_back_to_back: assert property (
    @(posedge clk) disable iff (reset)
    exec_en |=> !exec_en
  );

endmodule

// ==== verilog/cpu_top.sv ====
////////////////////////////////////////
// 8-bit CPU, one instruction per 2 clocks
// out_valid has no back-pressure, every
// pulse must be taken by the environment
////////////////////////////////////////

`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*; #(
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  run,
  input  logic                  load_en,
  input  logic [addr_width-1:0] load_addr,
  input  logic [data_width-1:0] load_data,
  input  logic [data_width-1:0] in_data,
  output logic [data_width-1:0] out_data,
  output logic                  out_valid
);

  logic                  fetch_en;
  logic                  exec_en;
  logic [addr_width-1:0] pc;
  logic [data_width-1:0] instr;

  cpu_sequencer u_sequencer (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .fetch_en (fetch_en),
    .exec_en  (exec_en)
  );

  program_counter #(.addr_width(addr_width)) u_pc (
    .clk     (clk),
    .reset   (reset),
    .exec_en (exec_en),
    .pc      (pc)
  );

  program_ram #(.addr_width(addr_width)) u_ram (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .fetch_en  (fetch_en),
    .pc        (pc),
    .instr     (instr)
  );

  cpu_datapath u_datapath (
    .clk       (clk),
    .reset     (reset),
    .exec_en   (exec_en),
    .instr     (instr),
    .in_data   (in_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

endmodule

// ==== verilog/program_counter.sv ====
////////////////////////////////////////
// counts executed instructions only
// wraps at the memory depth
////////////////////////////////////////

`timescale 1ns/1ps

module program_counter #(
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  exec_en,
  output logic [addr_width-1:0] pc
);

  // advance at the edge that ends the execute cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (exec_en) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

// ==== verilog/program_ram.sv ====
////////////////////////////////////////
// program store, 2**addr_width bytes
// load port writes on any edge with load_en
// read is registered, one cycle after fetch_en
////////////////////////////////////////

`timescale 1ns/1ps

module program_ram #(
  parameter int addr_width = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load_en,
  input  logic [addr_width-1:0] load_addr,
  input  logic [7:0]            load_data,
  input  logic                  fetch_en,
  input  logic [addr_width-1:0] pc,
  output logic [7:0]            instr
);

  localparam int depth = 2 ** addr_width;

  logic [7:0] mem [depth];

  // reset leaves an all-nop program
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= '0;
      end
      instr <= '0;
    end else begin
      if (load_en) begin
        mem[load_addr] <= load_data;
      end
      if (fetch_en) begin
        instr <= mem[pc];
      end
    end
  end

  load_addr_known: assert property (
    @(posedge clk) disable iff (reset)
    load_en |-> !$isunknown(load_addr)
  );

endmodule
